/* eth_tx_input.txt */
# len abort_cycle load_mode fcs, then the payload words in hex (fcs 0 = not tabulated)
# abort_cycle 0 = no abort; load_mode 1 = words written by the host during the previous frame
1 0 0 e8b7be43
61000000
4 0 0 2144df1c
00000000
5 0 0 3610a686
68656c6c 6f000000
64 0 1 00000000
00010203 04050607 08090a0b 0c0d0e0f 10111213 14151617 18191a1b 1c1d1e1f
20212223 24252627 28292a2b 2c2d2e2f 30313233 34353637 38393a3b 3c3d3e3f
20 150 0 00000000
a5a5a5a5 5a5a5a5a 0f0f0f0f f0f0f0f0 12345678
9 0 0 cbf43926
31323334 35363738 39000000
43 0 0 414fa339
54686520 71756963 6b206272 6f776e20 666f7820 6a756d70
73206f76 65722074 6865206c 617a7920 646f6700

/* filelist.f */
eth_tx_pkg.sv
frame_buffer.sv
buffer_arbiter.sv
tx_loader.sv
crc32_serial.sv
tx_serializer.sv
manchester_enc.sv
eth_tx_top.sv
tb_eth_tx_checker.sv
tb_eth_tx.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f filelist.f --top-module tb_eth_tx -o sim_eth_tx
out=$(./obj_dir/sim_eth_tx)
echo "$out"
echo "$out" | grep -q "PASS: all tests"

/* tb_eth_tx.sv */
`timescale 1ns/1ps

module tb_eth_tx import eth_tx_pkg::*;;

  localparam int EOF_HOLD = 6;

  logic             CLK;
  logic             RST;
  logic             start;
  logic             abort;
  logic [LEN_W-1:0] len;
  host_wr_t         host_wr;
  logic             line;
  logic             done;
  logic [31:0]      exp_words [128];
  logic [31:0]      exp_fcs;

  int          nfr = 0;
  int          flen [8];
  int          fab [8];   // abort offset, 0 for none
  int          fmode [8]; // 1 loads during the previous frame
  logic [31:0] ffcs [8];
  logic [31:0] fword [8][128];
  int          cycles = 0;
  int          limit = 1000000;

  eth_tx_top #(.BUF_DEPTH(512), .EOF_HOLD(EOF_HOLD)) UUT (
    .CLK(CLK), .RST(RST), .host_wr(host_wr), .start(start), .len(len),
    .abort(abort), .line(line), .done(done)
  );

  tb_eth_tx_checker #(.EOF_HOLD(EOF_HOLD)) chk (
    .CLK(CLK), .RST(RST), .start(start), .len(len), .abort(abort), .line(line),
    .done(done), .exp_words(exp_words), .exp_fcs(exp_fcs)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic load_file();
    int    fd;
    int    r;
    string hdr;
    fd = $fopen("eth_tx_input.txt", "r");
    if (fd == 0)
      $display("could not open eth_tx_input.txt");
    else
    begin
      r = $fgets(hdr, fd); // two column description lines
      r = $fgets(hdr, fd);
      r = $fscanf(fd, " %d %d %d %h", flen[nfr], fab[nfr], fmode[nfr], ffcs[nfr]);
      while (r == 4 && nfr < 8)
      begin
        for (int k = 0; k < (flen[nfr] + 3) / 4; k++)
          r = $fscanf(fd, " %h", fword[nfr][k]);
        nfr++;
        if (nfr < 8)
          r = $fscanf(fd, " %d %d %d %h", flen[nfr], fab[nfr], fmode[nfr], ffcs[nfr]);
      end
      $fclose(fd);
    end
  endtask

  task automatic preload(input int f);
    for (int i = 0; i < (flen[f] + 3) / 4; i++)
    begin
      @(negedge CLK);
      host_wr = '{valid: 1'b1, addr: ADDR_W'(i), data: fword[f][i]};
    end
    @(negedge CLK);
    host_wr = '0;
  endtask

  // host writes for frame n while frame f is on the line
  task automatic overlap_write(input int t, input int f, input int n);
    int wc;
    int wn;
    int base;
    wc   = (flen[f] + 3) / 4;
    wn   = (flen[n] + 3) / 4;
    base = 16 * (8 + flen[f]) + 8; // all words of frame f fetched by then
    if (t % 2 == 0 && wc + t / 2 < wn)
      host_wr = '{valid: 1'b1, addr: ADDR_W'(wc + t / 2), data: fword[n][wc + t / 2]};
    else if (t >= base && (t - base) % 2 == 0 && (t - base) / 2 < wc && (t - base) / 2 < wn)
      host_wr = '{valid: 1'b1, addr: ADDR_W'((t - base) / 2), data: fword[n][(t - base) / 2]};
  endtask

  task automatic send_frame(input int f);
    int t;
    bit fin;
    t   = 0;
    fin = 1'b0;
    while (!fin)
    begin
      @(negedge CLK);
      if (t == 0)
      begin
        for (int i = 0; i < 128; i++)
          exp_words[i] = fword[f][i];
        exp_fcs = ffcs[f];
        len     = LEN_W'(flen[f]);
      end
      start   = (t == 0) || (t == 40 && fab[f] == 0); // second one lands mid-frame
      abort   = (fab[f] != 0 && t == fab[f]);
      host_wr = '0;
      if (f + 1 < nfr && fmode[f + 1] == 1)
        overlap_write(t, f, f + 1);
      if (fab[f] != 0 && t == fab[f] + 30)
        fin = 1'b1;
      if (fab[f] == 0 && done)
        fin = 1'b1;
      t++;
    end
  endtask

  initial
  begin
    RST     = 1'b0;
    start   = 1'b0;
    abort   = 1'b0;
    len     = '0;
    host_wr = '0;
    exp_fcs = '0;
    for (int i = 0; i < 128; i++)
      exp_words[i] = '0;
    void'($urandom(61));
    load_file();
    limit = EOF_HOLD + 100;
    for (int f = 0; f < nfr; f++)
      limit = limit + (8 + flen[f] + 4) * 16;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    for (int f = 0; f < nfr; f++)
    begin
      @(negedge CLK);
      host_wr = '0;
      repeat (4 + $urandom % 8) @(negedge CLK);
      if (f == 0 || fmode[f] == 0)
        preload(f);
      send_frame(f);
    end
    @(negedge CLK);
    host_wr = '0;
    repeat (8) @(negedge CLK);
    if (chk.pass_cnt + chk.fail_cnt != nfr)
      $display("only %0d of %0d frames produced a result", chk.pass_cnt + chk.fail_cnt, nfr);
    $display("tests passed %0d failed %0d", chk.pass_cnt, chk.fail_cnt);
    if (nfr > 0 && chk.fail_cnt == 0 && chk.err_cnt == 0 && chk.pass_cnt == nfr)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tb_eth_tx_checker.sv */
`timescale 1ns/1ps

module tb_eth_tx_checker import eth_tx_pkg::*; #(
  parameter int EOF_HOLD = 6
) (
  input logic             CLK,
  input logic             RST,
  input logic             start,
  input logic [LEN_W-1:0] len,
  input logic             abort,
  input logic             line,
  input logic             done,
  input logic [31:0]      exp_words [128],
  input logic [31:0]      exp_fcs
);

  typedef enum {C_IDLE, C_LEAD, C_BITS, C_HOLD, C_ABORT} cstate_e;

  cstate_e     state = C_IDLE;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          err_cnt = 0;
  int          test_no = 0;
  int          frame_errs = 0;
  int          cnt;
  int          nbits;
  int          flen;
  logic [31:0] fcs;
  logic        first;
  logic        h;
  logic        prev;
  logic [7:0]  sh;

  function automatic logic [7:0] payload_byte(input int i);
    return exp_words[i / 4][31 - 8 * (i % 4) -: 8]; // msb byte of a word first
  endfunction

  // reflected crc-32, lsb of each byte first, complemented at the end
  function automatic logic [31:0] payload_fcs(input int n);
    logic [31:0] c;
    logic [7:0]  b;
    logic        fb;
    c = 32'hFFFFFFFF;
    for (int i = 0; i < n; i++)
    begin
      b = payload_byte(i);
      for (int k = 0; k < 8; k++)
      begin
        fb = c[0] ^ b[k];
        c = (c >> 1) ^ (fb ? 32'hEDB88320 : 32'h0);
      end
    end
    return ~c;
  endfunction

  function automatic logic [7:0] octet_at(input int idx);
    if (idx < 7)
      return 8'h55;
    if (idx == 7)
      return 8'hD5;
    if (idx < 8 + flen)
      return payload_byte(idx - 8);
    return fcs[8 * (idx - 8 - flen) +: 8]; // fcs low byte first
  endfunction

  task automatic flag(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    frame_errs++;
  endtask

  task automatic note(input string msg);
    $display("%s", msg);
    frame_errs++;
  endtask

  task automatic close_test(input string kind);
    test_no++;
    if (frame_errs == 0)
    begin
      pass_cnt++;
      $display("test %0d (%s, len %0d): ok", test_no, kind, flen);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d (%s, len %0d): failed", test_no, kind, flen);
    end
  endtask

  always @(posedge CLK)
  begin
    if (!RST)
      state = C_IDLE;
    else if (state != C_IDLE && state != C_ABORT && abort)
    begin
      state = C_ABORT; // line must toggle from the next sample on
      prev  = line;
      cnt   = 0;
    end
    else
    begin
      case (state)
        C_IDLE:
        begin
          if (done)
          begin
            $display("done pulsed outside a frame at %0t ns", $time);
            err_cnt++;
          end
          if (start && len != '0)
          begin
            flen       = int'(len);
            fcs        = payload_fcs(flen);
            frame_errs = 0;
            cnt        = 0;
            state      = C_LEAD;
            if (exp_fcs != 32'h0 && exp_fcs != fcs)
              flag($sformatf("computed fcs %h differs from file fcs %h", fcs, exp_fcs));
          end
        end
        C_LEAD:
        begin
          if (cnt == 2) // first half-bit is on the line at the next sample
          begin
            state = C_BITS;
            h     = 1'b0;
            nbits = 0;
          end
          else
            cnt++;
        end
        C_BITS:
        begin
          if (!h)
          begin
            first = line;
            h     = 1'b1;
          end
          else
          begin
            h = 1'b0;
            if (first == line)
              note($sformatf("invalid manchester pair at bit %0d, %0t ns", nbits, $time));
            sh = {line, sh[7:1]}; // lsb arrives first
            nbits++;
            if (nbits % 8 == 0 && sh !== octet_at(nbits / 8 - 1))
              flag($sformatf("octet %0d got %h expected %h", nbits / 8 - 1, sh,
                             octet_at(nbits / 8 - 1)));
            if (nbits == 8 * (12 + flen))
            begin
              state = C_HOLD;
              cnt   = 0;
            end
          end
        end
        C_HOLD:
        begin
          if (cnt < EOF_HOLD)
          begin
            if (line !== 1'b1 || done)
              flag($sformatf("end-of-frame hold broken in cycle %0d", cnt));
            cnt++;
          end
          else
          begin
            if (!(done && !line))
              note("done missing or line not low after the end-of-frame hold");
            close_test("frame");
            state = C_IDLE;
          end
        end
        C_ABORT:
        begin
          if (line === prev)
            flag("line did not toggle after abort");
          if (done)
            note("done appeared after an abort");
          prev = line;
          cnt++;
          if (cnt == 16)
          begin
            close_test("abort");
            state = C_IDLE;
          end
        end
        default: state = C_IDLE;
      endcase
    end
  end

endmodule

/* eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top import eth_tx_pkg::*; #(
  parameter int BUF_DEPTH = 512,
  parameter int EOF_HOLD  = 6
) (
  input  logic             CLK,
  input  logic             RST,
  input  host_wr_t         host_wr,
  input  logic             start,
  input  logic [LEN_W-1:0] len,
  input  logic             abort,
  output logic             line,
  output logic             done
);

  buf_req_t          req;
  logic [31:0]       mem_rdata;
  logic [31:0]       rd_data;
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  tx_phase_e         phase;
  logic              byte_req;
  logic [7:0]        data_byte;
  logic              last_byte;
  logic [1:0]        fcs_idx;
  logic [7:0]        fcs_byte;
  logic              crc_en;
  logic              crc_bit;
  logic              crc_clear;
  logic              bit_out;
  logic              bit_valid;
  logic              frame_end;
  wire               go = start && (len != '0); // empty frames never start

  frame_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buf (
    .CLK(CLK), .req(req), .rdata(mem_rdata)
  );

  buffer_arbiter #(.BUF_DEPTH(BUF_DEPTH)) u_arb (
    .CLK(CLK), .RST(RST), .host_wr(host_wr), .rd_en(rd_en), .rd_addr(rd_addr),
    .rd_data(rd_data), .req(req), .mem_rdata(mem_rdata)
  );

  tx_loader u_load (
    .CLK(CLK), .RST(RST), .start(go), .len(len), .phase(phase), .byte_req(byte_req),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .data_byte(data_byte),
    .last_byte(last_byte)
  );

  crc32_serial u_crc (
    .CLK(CLK), .RST(RST), .clear(crc_clear), .crc_en(crc_en), .crc_bit(crc_bit),
    .fcs_idx(fcs_idx), .fcs_byte(fcs_byte)
  );

  tx_serializer u_ser (
    .CLK(CLK), .RST(RST), .start(go), .abort(abort), .phase(phase),
    .byte_req(byte_req), .data_byte(data_byte), .last_byte(last_byte),
    .fcs_idx(fcs_idx), .fcs_byte(fcs_byte), .crc_en(crc_en), .crc_bit(crc_bit),
    .crc_clear(crc_clear), .bit_out(bit_out), .bit_valid(bit_valid),
    .frame_end(frame_end)
  );

  manchester_enc #(.EOF_HOLD(EOF_HOLD)) u_enc (
    .CLK(CLK), .RST(RST), .bit_out(bit_out), .bit_valid(bit_valid),
    .frame_end(frame_end), .abort(abort), .line(line), .done(done)
  );

endmodule

/* manchester_enc.sv */
`timescale 1ns/1ps

module manchester_enc #(
  parameter int EOF_HOLD = 6
) (
  input  logic CLK,
  input  logic RST,
  input  logic bit_out,
  input  logic bit_valid,
  input  logic frame_end,
  input  logic abort,
  output logic line,
  output logic done
);

  localparam int CNT_W = $clog2(EOF_HOLD + 1);

  logic             half;
  logic             aborting; // toggling until the next frame starts
  logic             holding;
  logic [CNT_W-1:0] hold_cnt;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      line     <= 1'b0;
      done     <= 1'b0;
      half     <= 1'b0;
      aborting <= 1'b0;
      holding  <= 1'b0;
      hold_cnt <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (abort || (aborting && !bit_valid))
      begin
        aborting <= 1'b1;
        holding  <= 1'b0;
        half     <= 1'b0;
        line     <= ~line;
      end
      else if (bit_valid)
      begin
        aborting <= 1'b0;
        half     <= ~half;
        line     <= half ? bit_out : ~bit_out; // complement first, then the bit
      end
      else
      begin
        half <= 1'b0;
        if (frame_end)
        begin
          line     <= 1'b1; // end-of-frame idle high
          holding  <= 1'b1;
          hold_cnt <= CNT_W'(EOF_HOLD - 1);
        end
        else if (holding)
        begin
          if (hold_cnt == '0)
          begin
            line    <= 1'b0;
            done    <= 1'b1;
            holding <= 1'b0;
          end
          else
            hold_cnt <= hold_cnt - 1'b1;
        end
      end
    end
  end

endmodule

/* tx_serializer.sv */
`timescale 1ns/1ps

module tx_serializer import eth_tx_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       start,
  input  logic       abort,
  output tx_phase_e  phase,
  output logic       byte_req,
  input  logic [7:0] data_byte,
  input  logic       last_byte,
  output logic [1:0] fcs_idx,
  input  logic [7:0] fcs_byte,
  output logic       crc_en,
  output logic       crc_bit,
  output logic       crc_clear,
  output logic       bit_out,
  output logic       bit_valid,
  output logic       frame_end
);

  logic       warm;  // one lead cycle after start
  logic       half;  // second cycle of the current bit
  logic [7:0] sreg;
  logic [2:0] bit_cnt;
  logic [2:0] oct_cnt;
  logic       act;
  logic       bit_tick;

  assign act = !warm && (phase inside {PH_PREAMBLE, PH_SFD, PH_DATA, PH_FCS});
  assign bit_tick  = act && half;
  assign byte_req  = bit_tick && (bit_cnt == 3'd6) && (phase inside {PH_SFD, PH_DATA});
  assign fcs_idx   = (phase == PH_FCS) ? oct_cnt[1:0] + 2'd1 : 2'd0; // byte loaded next
  assign crc_clear = start && (phase == PH_IDLE) && !abort;
  assign crc_en    = act && !half && (phase == PH_DATA); // ahead of the shift edge
  assign crc_bit   = sreg[0];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      phase     <= PH_IDLE;
      warm      <= 1'b0;
      half      <= 1'b0;
      bit_cnt   <= '0;
      oct_cnt   <= '0;
      bit_out   <= 1'b0;
      bit_valid <= 1'b0;
      frame_end <= 1'b0;
    end
    else
    begin
      bit_out   <= sreg[0];
      bit_valid <= act && !abort;
      frame_end <= (phase == PH_EOF) && !abort;
      if (abort)
      begin
        phase <= PH_IDLE; // frame dropped
        warm  <= 1'b0;
        half  <= 1'b0;
      end
      else if (crc_clear)
      begin
        phase   <= PH_PREAMBLE;
        warm    <= 1'b1;
        half    <= 1'b0;
        bit_cnt <= '0;
        oct_cnt <= '0;
        sreg    <= PREAMBLE_BYTE;
      end
      else
      begin
        warm <= 1'b0;
        if (phase == PH_EOF)
          phase <= PH_IDLE;
        if (act)
          half <= ~half;
        if (bit_tick)
        begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt != 3'd7)
            sreg <= {1'b0, sreg[7:1]}; // lsb first
          else
          begin
            case (phase)
              PH_PREAMBLE:
              begin
                if (oct_cnt == 3'(PREAMBLE_OCTETS - 1))
                begin
                  phase   <= PH_SFD;
                  oct_cnt <= '0;
                  sreg    <= SFD_BYTE;
                end
                else
                begin
                  oct_cnt <= oct_cnt + 3'd1;
                  sreg    <= PREAMBLE_BYTE;
                end
              end
              PH_SFD:
              begin
                phase <= PH_DATA;
                sreg  <= data_byte;
              end
              PH_DATA:
              begin
                if (last_byte)
                begin
                  phase   <= PH_FCS;
                  oct_cnt <= '0;
                  sreg    <= fcs_byte;
                end
                else
                  sreg <= data_byte;
              end
              PH_FCS:
              begin
                if (oct_cnt == 3'd3)
                  phase <= PH_EOF;
                else
                begin
                  oct_cnt <= oct_cnt + 3'd1;
                  sreg    <= fcs_byte;
                end
              end
              default: phase <= PH_IDLE;
            endcase
          end
        end
      end
    end
  end

  // a stale last_byte would end the payload early
  a_data_until_last: assert property (@(posedge CLK) disable iff (!RST)
    (phase == PH_PREAMBLE || phase == PH_SFD) |-> !last_byte)
    else $error("tx_serializer: last_byte set before the data phase");

endmodule

/* crc32_serial.sv */
`timescale 1ns/1ps

module crc32_serial import eth_tx_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       clear,
  input  logic       crc_en,
  input  logic       crc_bit,
  input  logic [1:0] fcs_idx,
  output logic [7:0] fcs_byte
);

  logic [31:0] crc;
  logic [31:0] fcs;
  logic        fb;

  assign fb       = crc[0] ^ crc_bit;
  assign fcs      = ~crc;
  assign fcs_byte = fcs[{fcs_idx, 3'b000} +: 8]; // byte 0 is the low byte

  always_ff @(posedge CLK)
  begin
    if (!RST)
      crc <= '1;
    else if (clear)
      crc <= '1; // preset for a new frame
    else if (crc_en)
      crc <= {1'b0, crc[31:1]} ^ (fb ? CRC_POLY : 32'h0);
  end

endmodule

/* tx_loader.sv */
`timescale 1ns/1ps

module tx_loader import eth_tx_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [LEN_W-1:0]  len,
  input  tx_phase_e         phase,
  input  logic              byte_req,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [31:0]       rd_data,
  output logic [7:0]        data_byte,
  output logic              last_byte
);

  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  cnt;    // bytes staged so far
  logic [LEN_W:0]    cnt_nx;
  logic [1:0]        bsel;   // 0 selects the top byte
  logic [ADDR_W-1:0] addr;   // next word to fetch
  logic [31:0]       word;
  logic              rd_pend;
  logic              launch;
  logic              stage;
  logic              fetch;

  assign launch  = start && (phase == PH_IDLE);
  assign cnt_nx  = cnt + 1'b1;
  assign stage   = byte_req && (cnt < len_q);
  assign fetch   = stage && (bsel == 2'd3) && (cnt_nx < {1'b0, len_q}); // more words left
  assign rd_en   = launch || fetch;
  assign rd_addr = launch ? '0 : addr;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      len_q     <= '0;
      cnt       <= '0;
      bsel      <= '0;
      addr      <= '0;
      rd_pend   <= 1'b0;
      last_byte <= 1'b0;
    end
    else
    begin
      rd_pend <= rd_en;
      if (launch)
      begin
        len_q     <= len;
        cnt       <= '0;
        bsel      <= '0;
        addr      <= ADDR_W'(1); // word 0 is read right now
        last_byte <= 1'b0;
      end
      else if (byte_req)
      begin
        if (stage)
        begin
          cnt  <= cnt_nx[LEN_W-1:0];
          bsel <= bsel + 2'd1;
          if (fetch)
            addr <= addr + 1'b1;
        end
        else
          last_byte <= 1'b1; // nothing left, current byte is the final one
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (rd_pend)
      word <= rd_data;
    if (stage)
      data_byte <= word[{~bsel, 3'b000} +: 8]; // msb byte first
  end

endmodule

/* buffer_arbiter.sv */
`timescale 1ns/1ps

module buffer_arbiter import eth_tx_pkg::*; #(
  parameter int BUF_DEPTH = 512
) (
  input  logic              CLK,
  input  logic              RST,
  input  host_wr_t          host_wr,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [31:0]       rd_data,
  output buf_req_t          req,
  input  logic [31:0]       mem_rdata
);

  host_wr_t pend; // host write parked behind a transmit read

  assign rd_data = mem_rdata;

  always_comb
  begin
    req = '0;
    if (rd_en)
    begin
      req.valid = 1'b1; // transmit side always wins
      req.addr  = rd_addr;
    end
    else if (pend.valid)
    begin
      req.valid = 1'b1;
      req.write = 1'b1;
      req.addr  = pend.addr;
      req.data  = pend.data;
    end
    else if (host_wr.valid)
    begin
      req.valid = 1'b1;
      req.write = 1'b1;
      req.addr  = host_wr.addr;
      req.data  = host_wr.data;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
      pend.valid <= 1'b0;
    else if (rd_en && host_wr.valid)
      pend <= host_wr; // collision, commit later
    else if (!rd_en)
      pend.valid <= 1'b0; // drained this cycle
  end

  a_one_pending: assert property (@(posedge CLK) disable iff (!RST)
    pend.valid |-> !host_wr.valid)
    else $error("buffer_arbiter: host write while another is pending");

  a_host_addr: assert property (@(posedge CLK) disable iff (!RST)
    host_wr.valid |-> (int'(host_wr.addr) < BUF_DEPTH))
    else $error("buffer_arbiter: host address %0d out of range", host_wr.addr);

endmodule

/* frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer import eth_tx_pkg::*; #(
  parameter int BUF_DEPTH = 512
) (
  input  logic        CLK,
  input  buf_req_t    req,
  output logic [31:0] rdata
);

  logic [31:0] mem [BUF_DEPTH];

  always_ff @(posedge CLK)
  begin
    if (req.valid)
    begin
      if (req.write)
        mem[req.addr] <= req.data;
      else
        rdata <= mem[req.addr]; // registered read, one cycle latency
    end
  end

  a_addr_range: assert property (@(posedge CLK)
    req.valid |-> (int'(req.addr) < BUF_DEPTH))
    else $error("frame_buffer: address %0d beyond depth %0d", req.addr, BUF_DEPTH);

endmodule

/* eth_tx_pkg.sv */
package eth_tx_pkg;

  localparam int ADDR_W          = 9;  // frame buffer word address
  localparam int LEN_W           = 11; // frame length in bytes
  localparam int PREAMBLE_OCTETS = 7;

  localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0]  SFD_BYTE      = 8'hD5;
  localparam logic [31:0] CRC_POLY      = 32'hEDB88320; // reflected 802.3 polynomial

  // one host word write, valid for a single cycle
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
  } host_wr_t;

  // access presented to the buffer RAM
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
  } buf_req_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_PREAMBLE,
    PH_SFD,
    PH_DATA,
    PH_FCS,
    PH_EOF
  } tx_phase_e;

endpackage
